// File: include/rv_core_config.svh
// RV64I core configuration

`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// Data path widths
`define RV_XLEN       64
`define RV_SHAMT_W    6

// General register file
`define RV_REG_NUM    32
`define RV_REG_IDX_W  5

// Major opcodes handled by the decoder
`define RV_OPC_OP     7'b0110011
`define RV_OPC_OP_IMM 7'b0010011

`endif

// File: src/rv_core_pkg.sv
// RV64I core types

`default_nettype none

package rv_core_pkg;

    `include "rv_core_config.svh"

    typedef logic [`RV_XLEN-1:0]      rv_xlen_t;
    typedef logic [`RV_REG_IDX_W-1:0] rv_reg_idx_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction formats
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic [6:0]  funct7;
        rv_reg_idx_t rs2;
        rv_reg_idx_t rs1;
        logic [2:0]  funct3;
        rv_reg_idx_t rd;
        logic [6:0]  opcode;
    } rv_rtype_t;

    typedef struct packed {
        logic [11:0] imm12;
        rv_reg_idx_t rs1;
        logic [2:0]  funct3;
        rv_reg_idx_t rd;
        logic [6:0]  opcode;
    } rv_itype_t;

    // Same word, read by opcode
    typedef union packed {
        rv_rtype_t r;
        rv_itype_t i;
    } rv_inst_u;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_and,
        alu_or,  alu_xor, alu_sll, alu_srl,  alu_sra
    } rv_alu_op_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage records
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic        valid;
        rv_reg_idx_t rd;
        rv_reg_idx_t rs1;
        rv_reg_idx_t rs2;
        rv_alu_op_e  alu_op;
        logic        use_imm;
        rv_xlen_t    src1;
        rv_xlen_t    src2;
        rv_xlen_t    imm;
    } rv_dec_op_t;

    typedef struct packed {
        logic        valid;
        rv_reg_idx_t rd;
        rv_xlen_t    data;
    } rv_wb_t;

endpackage

`default_nettype wire

// File: src/rv_regfile.sv
// General register file

`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module rv_regfile (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  rv_core_pkg::rv_reg_idx_t rs1_i,
    input  rv_core_pkg::rv_reg_idx_t rs2_i,
    input  rv_core_pkg::rv_wb_t    wb_i,
    output rv_core_pkg::rv_xlen_t  rs1_data_o,
    output rv_core_pkg::rv_xlen_t  rs2_data_o
);
    import rv_core_pkg::*;

    // x0 has no storage
    rv_xlen_t regs [1:`RV_REG_NUM-1];

    function automatic rv_xlen_t read_port(input rv_reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end else if (wb_i.valid && (wb_i.rd == idx)) begin
            // Write-through for a read in the write cycle
            return wb_i.data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_i);
        rs2_data_o = read_port(rs2_i);
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < `RV_REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.valid && (wb_i.rd != '0)) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

endmodule

`default_nettype wire

// File: src/rv_decode_stage.sv
// Decode and register read stage

`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module rv_decode_stage (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic                     inst_valid_i,
    input  rv_core_pkg::rv_inst_u    inst_i,
    input  rv_core_pkg::rv_xlen_t    rs1_data_i,
    input  rv_core_pkg::rv_xlen_t    rs2_data_i,
    output rv_core_pkg::rv_reg_idx_t rs1_o,
    output rv_core_pkg::rv_reg_idx_t rs2_o,
    output rv_core_pkg::rv_dec_op_t  op_o
);
    import rv_core_pkg::*;

    logic       is_op;
    logic       is_op_imm;
    logic [2:0] funct3;
    logic       f7_base;
    logic       f7_alt;
    logic       sh_base;
    logic       sh_alt;
    logic       legal;
    rv_alu_op_e alu_op;
    rv_dec_op_t op_d;
    rv_dec_op_t op_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Field decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign is_op     = (inst_i.r.opcode == `RV_OPC_OP);
    assign is_op_imm = (inst_i.r.opcode == `RV_OPC_OP_IMM);
    assign funct3    = inst_i.r.funct3;

    assign f7_base = (inst_i.r.funct7 == 7'b0000000);
    assign f7_alt  = (inst_i.r.funct7 == 7'b0100000);

    // Immediate shifts carry a 6-bit shamt, the rest selects the kind
    assign sh_base = (inst_i.i.imm12[11:`RV_SHAMT_W] == 6'b000000);
    assign sh_alt  = (inst_i.i.imm12[11:`RV_SHAMT_W] == 6'b010000);

    always_comb begin
        alu_op = alu_add;
        legal  = 1'b0;
        if (is_op) begin
            legal = f7_base;
            case (funct3)
                3'b000: begin
                    alu_op = f7_alt ? alu_sub : alu_add;
                    legal  = f7_base || f7_alt;
                end
                3'b001: alu_op = alu_sll;
                3'b010: alu_op = alu_slt;
                3'b011: alu_op = alu_sltu;
                3'b100: alu_op = alu_xor;
                3'b101: begin
                    alu_op = f7_alt ? alu_sra : alu_srl;
                    legal  = f7_base || f7_alt;
                end
                3'b110: alu_op = alu_or;
                default: alu_op = alu_and;
            endcase
        end else if (is_op_imm) begin
            legal = 1'b1;
            case (funct3)
                3'b000: alu_op = alu_add;
                3'b001: begin
                    alu_op = alu_sll;
                    legal  = sh_base;
                end
                3'b010: alu_op = alu_slt;
                3'b011: alu_op = alu_sltu;
                3'b100: alu_op = alu_xor;
                3'b101: begin
                    alu_op = sh_alt ? alu_sra : alu_srl;
                    legal  = sh_base || sh_alt;
                end
                3'b110: alu_op = alu_or;
                default: alu_op = alu_and;
            endcase
        end
    end

    // No rs2 for OP-IMM, so index zero keeps forwarding quiet
    assign rs1_o = inst_i.i.rs1;
    assign rs2_o = is_op_imm ? '0 : inst_i.r.rs2;

    always_comb begin
        op_d.valid   = inst_valid_i && legal;
        op_d.rd      = inst_i.r.rd;
        op_d.rs1     = rs1_o;
        op_d.rs2     = rs2_o;
        op_d.alu_op  = alu_op;
        op_d.use_imm = is_op_imm;
        op_d.src1    = rs1_data_i;
        op_d.src2    = rs2_data_i;
        op_d.imm     = {{(`RV_XLEN-12){inst_i.i.imm12[11]}}, inst_i.i.imm12};
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode to execute register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            op_q.valid <= 1'b0;
        end else begin
            op_q <= op_d;
        end
    end

    assign op_o = op_q;

endmodule

`default_nettype wire

// File: src/rv_exec_stage.sv
// Execute stage

`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module rv_exec_stage (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  rv_core_pkg::rv_dec_op_t op_i,
    output rv_core_pkg::rv_wb_t     wb_o
);
    import rv_core_pkg::*;

    logic                   fwd_rs1;
    logic                   fwd_rs2;
    rv_xlen_t               opa;
    rv_xlen_t               opb_reg;
    rv_xlen_t               opb;
    logic [`RV_SHAMT_W-1:0] shamt;
    rv_xlen_t               result;
    rv_wb_t                 wb_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operand forwarding
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Producer one slot ahead sits in our own write-back register
    assign fwd_rs1 = wb_q.valid && (wb_q.rd != '0) && (wb_q.rd == op_i.rs1);
    assign fwd_rs2 = wb_q.valid && (wb_q.rd != '0) && (wb_q.rd == op_i.rs2);

    assign opa     = fwd_rs1 ? wb_q.data : op_i.src1;
    assign opb_reg = fwd_rs2 ? wb_q.data : op_i.src2;
    assign opb     = op_i.use_imm ? op_i.imm : opb_reg;

    assign shamt = opb[`RV_SHAMT_W-1:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ALU
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (op_i.alu_op)
            alu_add: result = opa + opb;
            alu_sub: result = opa - opb;
            alu_slt: begin
                result = {{(`RV_XLEN-1){1'b0}}, ($signed(opa) < $signed(opb))};
            end
            alu_sltu: begin
                result = {{(`RV_XLEN-1){1'b0}}, (opa < opb)};
            end
            alu_and: result = opa & opb;
            alu_or:  result = opa | opb;
            alu_xor: result = opa ^ opb;
            alu_sll: result = opa << shamt;
            alu_srl: result = opa >> shamt;
            alu_sra: result = rv_xlen_t'($signed(opa) >>> shamt);
            default: result = '0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write-back register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_q.valid <= 1'b0;
        end else begin
            wb_q.valid <= op_i.valid;
            wb_q.rd    <= op_i.rd;
            wb_q.data  <= result;
        end
    end

    assign wb_o = wb_q;

endmodule

`default_nettype wire

// File: src/rv_core_top.sv
// RV64I integer core

`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic                     inst_valid_i,
    input  logic [31:0]              inst_i,
    output logic                     wb_valid_o,
    output rv_core_pkg::rv_reg_idx_t wb_rd_o,
    output rv_core_pkg::rv_xlen_t    wb_data_o
);
    import rv_core_pkg::*;

    rv_reg_idx_t dec_rs1;
    rv_reg_idx_t dec_rs2;
    rv_xlen_t    rf_rs1_data;
    rv_xlen_t    rf_rs2_data;
    rv_dec_op_t  dec_op;
    rv_wb_t      wb;

    rv_decode_stage u_decode (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .rs1_data_i   (rf_rs1_data),
        .rs2_data_i   (rf_rs2_data),
        .rs1_o        (dec_rs1),
        .rs2_o        (dec_rs2),
        .op_o         (dec_op)
    );

    rv_regfile u_regfile (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rs1_i      (dec_rs1),
        .rs2_i      (dec_rs2),
        .wb_i       (wb),
        .rs1_data_o (rf_rs1_data),
        .rs2_data_o (rf_rs2_data)
    );

    rv_exec_stage u_exec (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .op_i     (dec_op),
        .wb_o     (wb)
    );

    // Retired record to the core ports
    assign wb_valid_o = wb.valid;
    assign wb_rd_o    = wb.rd;
    assign wb_data_o  = wb.data;

endmodule

`default_nettype wire

// File: sim/rv_core_assertions.sv
// Core port assertions

`timescale 1ns/1ps
`default_nettype none

module rv_core_assertions (
    input logic                     clk,
    input logic                     arst_n_i,
    input logic                     inst_valid_i,
    input logic                     wb_valid_i,
    input rv_core_pkg::rv_reg_idx_t wb_rd_i
);

    // Nothing retires while the core is held in reset
    a_no_wb_in_reset: assert property (@(posedge clk) !arst_n_i |-> !wb_valid_i)
        else $error("wb_valid_o high during reset");

    // Two register stages, so each retirement was accepted two edges back
    a_wb_latency: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_valid_i |-> $past(inst_valid_i, 2))
        else $error("wb_valid_o without an accepted instruction two cycles earlier");

    a_wb_rd_known: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_valid_i |-> !$isunknown(wb_rd_i))
        else $error("wb_rd_o has unknown bits on a write-back");

endmodule

bind rv_core_top rv_core_assertions u_rv_core_assertions (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .inst_valid_i (inst_valid_i),
    .wb_valid_i   (wb_valid_o),
    .wb_rd_i      (wb_rd_o)
);

`default_nettype wire

// File: sim/rv_core_tb.sv
// RV64I core testbench

`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;
    import rv_core_pkg::*;

    localparam int f3_add  = 0;
    localparam int f3_sll  = 1;
    localparam int f3_slt  = 2;
    localparam int f3_sltu = 3;
    localparam int f3_xor  = 4;
    localparam int f3_sr   = 5;
    localparam int f3_or   = 6;
    localparam int f3_and  = 7;
    localparam int f7_base = 0;
    localparam int f7_alt  = 32;
    localparam logic retire = 1'b1;
    localparam logic bubble = 1'b0;

    typedef struct packed {
        logic [31:0] inst;
        logic [7:0]  gap;
        logic        retires;
    } stim_t;

    typedef struct packed {
        logic [31:0] due;
        rv_reg_idx_t rd;
        rv_xlen_t    data;
    } exp_t;

    logic        clk;
    logic        arst_n_i;
    logic        inst_valid_i;
    logic [31:0] inst_i;
    logic        wb_valid_o;
    rv_reg_idx_t wb_rd_o;
    rv_xlen_t    wb_data_o;

    stim_t       stim_q[$];
    exp_t        exp_q[$];
    rv_xlen_t    model_regs[32];
    logic [31:0] lcg_state;
    int          cycle;
    int          run_cycles;
    int          cycle_limit;
    int          errors;

    rv_core_top u_rv_core_top (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Encoding and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] r_format(input int funct7, input int rs2, input int rs1,
                                             input int funct3, input int rd);
        return {7'(funct7), 5'(rs2), 5'(rs1), 3'(funct3), 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] i_format(input logic [11:0] imm, input int rs1,
                                             input int funct3, input int rd);
        return {imm, 5'(rs1), 3'(funct3), 5'(rd), 7'b0010011};
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Result of a legal OP or OP-IMM word against the model registers
    function automatic rv_xlen_t reference_result(input logic [31:0] inst);
        rv_xlen_t   a;
        rv_xlen_t   b;
        logic [5:0] sh;
        logic       is_imm;
        is_imm = (inst[6:0] == 7'b0010011);
        a      = model_regs[inst[19:15]];
        b      = is_imm ? {{52{inst[31]}}, inst[31:20]} : model_regs[inst[24:20]];
        sh     = b[5:0];
        case (inst[14:12])
            3'b000:  return (inst[30] && !is_imm) ? a - b : a + b;
            3'b001:  return a << sh;
            3'b010:  return {63'd0, $signed(a) < $signed(b)};
            3'b011:  return {63'd0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return inst[30] ? 64'($signed(a) >>> sh) : a >> sh;
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic add_entry(input logic [31:0] inst, input int gap, input logic retires);
        stim_t s;
        s.inst    = inst;
        s.gap     = 8'(gap);
        s.retires = retires;
        stim_q.push_back(s);
    endtask

    task automatic add_random_gap(input logic [31:0] inst, input logic retires);
        lcg_state = lcg_next(lcg_state);
        add_entry(inst, int'(lcg_state[17:16]), retires);
    endtask

    task automatic build_table();
        // Nothing legal yet, so no write-back may appear
        add_entry(32'h0000_0000, 1, bubble);
        add_entry({20'h12345, 5'd1, 7'b0110111}, 0, bubble);
        // Negative immediates and 6-bit shift amounts
        add_entry(i_format(12'hffb, 0, f3_add, 1), 2, retire);
        add_entry(i_format(12'h7ff, 0, f3_add, 2), 2, retire);
        add_entry(i_format({6'b000000, 6'd52}, 2, f3_sll, 3), 2, retire);
        add_entry(i_format(12'h123, 3, f3_or, 3), 2, retire);
        add_entry(i_format({6'b010000, 6'd1}, 1, f3_sr, 4), 2, retire);
        add_entry(i_format({6'b000000, 6'd40}, 3, f3_sr, 5), 2, retire);
        add_entry(i_format(12'hfff, 1, f3_xor, 6), 2, retire);
        add_entry(i_format(12'h000, 1, f3_slt, 7), 2, retire);
        add_entry(i_format(12'h005, 1, f3_sltu, 8), 2, retire);
        add_entry(i_format(12'hff0, 3, f3_and, 9), 2, retire);
        // Register forms read the immediate results back
        add_entry(r_format(f7_base, 2, 1, f3_add, 10), 1, retire);
        add_entry(r_format(f7_alt, 3, 1, f3_add, 11), 1, retire);
        add_entry(r_format(f7_base, 2, 1, f3_slt, 12), 1, retire);
        add_entry(r_format(f7_base, 2, 1, f3_sltu, 13), 1, retire);
        add_entry(r_format(f7_base, 1, 3, f3_and, 14), 1, retire);
        add_entry(r_format(f7_base, 5, 4, f3_or, 15), 1, retire);
        add_entry(r_format(f7_base, 4, 3, f3_xor, 16), 1, retire);
        add_entry(r_format(f7_base, 4, 2, f3_sll, 17), 1, retire);
        add_entry(r_format(f7_base, 2, 3, f3_sr, 18), 1, retire);
        add_entry(r_format(f7_alt, 6, 1, f3_sr, 19), 1, retire);
        // Undefined funct7, shift kind and opcode
        add_entry(r_format(1, 2, 1, f3_add, 20), 1, bubble);
        add_entry(r_format(f7_alt, 2, 1, f3_sll, 20), 1, bubble);
        add_entry(i_format({6'b010000, 6'd3}, 1, f3_sll, 20), 1, bubble);
        add_entry({7'd0, 5'd2, 5'd1, 3'd0, 5'd20, 7'b0111011}, 1, bubble);
        // x0 as destination retires, and reads of x0 stay zero right after
        add_entry(i_format(12'h007, 1, f3_add, 0), 0, retire);
        add_entry(r_format(f7_base, 0, 1, f3_add, 21), 0, retire);
        add_entry(r_format(f7_base, 0, 0, f3_add, 22), 1, retire);
        // Dependent chain at distances one, two and three
        add_entry(r_format(f7_base, 3, 10, f3_add, 23), 0, retire);
        add_entry(r_format(f7_alt, 1, 23, f3_add, 24), 0, retire);
        add_entry(r_format(f7_base, 24, 23, f3_add, 25), 0, retire);
        add_entry(r_format(f7_base, 25, 23, f3_xor, 26), 0, retire);
        add_entry(r_format(f7_base, 26, 2, f3_sll, 27), 0, retire);
        add_entry(r_format(f7_alt, 27, 24, f3_sr, 28), 2, retire);
        // Stream with random gaps, each op reads the previous result
        for (int k = 0; k < 16; k++) begin
            if (k % 5 == 4) begin
                add_random_gap(r_format(1, k, k + 1, f3_add, 31), bubble);
            end else if (k % 3 == 2) begin
                add_random_gap(i_format(12'(k * 91 - 600), 9 + k,
                                        (k % 2 == 0) ? f3_add : f3_xor, 10 + k), retire);
            end else begin
                add_random_gap(r_format((k % 8 == 5 || k == 0) ? f7_alt : f7_base,
                                        k + 1, 9 + k, k % 8, 10 + k), retire);
            end
        end
    endtask

    function automatic int run_length();
        int total;
        total = 0;
        foreach (stim_q[n]) begin
            total = total + 1 + int'(stim_q[n].gap);
        end
        return total;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Drive and check
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            errors = errors + 1;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic sample_outputs();
        exp_t e;
        if (!arst_n_i) begin
            check_value("wb_valid_o", 64'(wb_valid_o), 64'd0);
        end else if (wb_valid_o) begin
            if (exp_q.size() == 0) begin
                errors = errors + 1;
                $display("Unexpected write-back to x%0d at %0t with nothing outstanding",
                         wb_rd_o, $time);
            end else begin
                e = exp_q.pop_front();
                check_value("wb_valid_o cycle", 64'(cycle), 64'(e.due));
                check_value("wb_rd_o", 64'(wb_rd_o), 64'(e.rd));
                check_value("wb_data_o", wb_data_o, e.data);
            end
        end
    endtask

    // Outputs are registered, so the falling edge sees them settled
    task automatic advance();
        @(negedge clk);
        cycle = cycle + 1;
        sample_outputs();
    endtask

    task automatic issue(input stim_t s);
        exp_t e;
        inst_valid_i = 1'b1;
        inst_i       = s.inst;
        if (s.retires) begin
            e.due  = 32'(cycle + 2);
            e.rd   = s.inst[11:7];
            e.data = reference_result(s.inst);
            exp_q.push_back(e);
            if (e.rd != '0) begin
                model_regs[e.rd] = e.data;
            end
        end
    endtask

    always @(posedge clk) begin
        run_cycles = run_cycles + 1;
        if (run_cycles > cycle_limit) begin
            $display("Timeout after %0d cycles with %0d write-backs outstanding",
                     cycle_limit, exp_q.size());
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        arst_n_i     = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        errors       = 0;
        cycle        = 0;
        lcg_state    = 32'h64b1;
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        build_table();
        cycle_limit = run_length() + 50;

        repeat (4) advance();
        arst_n_i = 1'b1;

        foreach (stim_q[n]) begin
            advance();
            issue(stim_q[n]);
            repeat (stim_q[n].gap) begin
                advance();
                inst_valid_i = 1'b0;
            end
        end
        advance();
        inst_valid_i = 1'b0;
        // Latency is fixed at two cycles, so the pipe is empty after this
        repeat (3) advance();

        if (exp_q.size() != 0) begin
            errors = errors + 1;
            $display("%0d expected write-backs never appeared", exp_q.size());
        end
        $display("Run finished after %0d cycles with %0d errors", cycle, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
src/rv_core_pkg.sv
src/rv_regfile.sv
src/rv_decode_stage.sv
src/rv_exec_stage.sv
src/rv_core_top.sv
sim/rv_core_assertions.sv
sim/rv_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the RV64I core testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f all.f \
    --top-module rv_core_tb \
    -o rv_core_sim

./obj_dir/rv_core_sim | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
echo "Simulation finished, see sim.log"
